// ==== hw/issue_ctrl.sv ====
//======================================================================
// issue controller for the forward pipeline, one item every other cycle
// priority: break head, head with memory, fresh read, else a bubble
// new_read is combinational and the loader consumes on that edge
// fwd_out trails the pop decision by two unstalled edges
//======================================================================
`timescale 1ns/1ps

module issue_ctrl
	import smem_queue_pkg::*;
(
	input  logic         Clk_32UI,
	input  logic         reset_n,
	input  logic         stall,
	input  queue_entry_t head,
	input  logic         queue_empty,
	input  logic         occ_valid,
	input  logic         new_read_valid,
	input  new_read_t    new_read_in,
	output logic         queue_pop,
	output logic         occ_pop,
	output logic         new_read,
	output queue_entry_t fwd_out
);

	logic         last_issue;  // set = just issued, next slot is a bubble
	logic         head_break;
	logic         take_break;
	logic         take_mem;
	queue_entry_t issue_q;
	queue_entry_t fresh;

	//======================================================================
	// issue decision
	//======================================================================
	assign head_break = !queue_empty && (head.item.status == ST_F_BREAK);
	assign take_break = !stall && !last_issue && head_break;
	assign take_mem   = !stall && !last_issue && !queue_empty && !head_break && occ_valid;

	// memory FIFO must be empty, and a break head goes first
	assign new_read = new_read_valid && !occ_valid && !stall && !last_issue && !head_break;

	assign queue_pop = take_break || take_mem;
	assign occ_pop   = take_mem;

	// first round of a new read needs no query base
	always_comb begin
		fresh.item.status     = ST_F_INIT;
		fresh.item.ptr_curr   = '0;
		fresh.item.read_num   = new_read_in.read_num;
		fresh.item.ik         = new_read_in.ik;
		fresh.item.forward_i  = new_read_in.forward_i + 1'b1;
		fresh.item.backward_x = new_read_in.forward_i;
		fresh.item.min_intv   = new_read_in.min_intv;
		fresh.query           = '0;
	end

	//======================================================================
	// issue register and state
	//======================================================================
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			last_issue            <= 1'b0;
			issue_q.item.status   <= ST_BUBBLE;
		end else if (!stall) begin
			if (last_issue) begin
				issue_q.item.status <= ST_BUBBLE;
				last_issue          <= 1'b0;
			end else if (queue_pop) begin
				issue_q    <= head;  // break or head with memory
				last_issue <= 1'b1;
			end else if (new_read) begin
				issue_q    <= fresh;
				last_issue <= 1'b1;
			end else begin
				issue_q.item.status <= ST_BUBBLE;  // nothing to send, stay ready
			end
		end
	end

	// output register, held through stall
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			fwd_out.item.status <= ST_BUBBLE;
		end else if (!stall) begin
			fwd_out <= issue_q;
		end
	end

endmodule

// ==== hw/occ_fifo.sv ====
//======================================================================
// FIFO of DRAM occurrence-count responses, MAX_READ deep
// the write side runs through stall, the producer must not overflow it
// a pop registers the head, the output register adds one more edge so
// occ_out appears on the same edge as the matching fwd_out
//======================================================================
`timescale 1ns/1ps

module occ_fifo
	import smem_queue_pkg::*;
(
	input  logic       Clk_32UI,
	input  logic       reset_n,
	input  logic       stall,
	input  logic       dram_get,
	input  occ_entry_t occ_in,
	input  logic       pop,
	output logic       occ_valid,
	output occ_entry_t occ_out
);

	occ_entry_t            mem [MAX_READ];
	logic [READ_NUM_W:0]   wr_ptr;    // extra bit tells full from empty
	logic [READ_NUM_W:0]   rd_ptr;
	occ_entry_t            pop_data;  // head taken at the pop edge

	//======================================================================
	// write side, ignores stall
	//======================================================================
	always_ff @(posedge Clk_32UI) begin
		if (dram_get) begin
			mem[wr_ptr[READ_NUM_W-1:0]] <= occ_in;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
		end else if (dram_get) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	//======================================================================
	// read side
	//======================================================================
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			rd_ptr <= '0;
		end else if (pop && !stall) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// payload path, lines up with issue and output register
	always_ff @(posedge Clk_32UI) begin
		if (pop && !stall) begin
			pop_data <= mem[rd_ptr[READ_NUM_W-1:0]];
		end
		if (!stall) begin
			occ_out <= pop_data;
		end
	end

	assign occ_valid = (wr_ptr != rd_ptr);

endmodule

// ==== hw/query_align.sv ====
//======================================================================
// delay line that waits out the read RAM latency for each item
// query_base must belong to the item leaving the last stage, i.e. it
// arrives QUERY_LAT unstalled edges after the item was captured
// stall holds every stage, so the RAM side has to hold its data as well
//======================================================================
`timescale 1ns/1ps

module query_align
	import smem_queue_pkg::*;
(
	input  logic               Clk_32UI,
	input  logic               reset_n,
	input  logic               stall,
	input  fwd_item_t          fwd_in,
	input  logic [QUERY_W-1:0] query_base,
	output queue_entry_t       entry_out
);

	fwd_item_t stage [QUERY_LAT];  // stage 0 captures fwd_in

	//======================================================================
	// latency stages, then join with the returned base
	//======================================================================
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			for (int i = 0; i < QUERY_LAT; i++) begin
				stage[i].status <= ST_BUBBLE;
			end
			entry_out.item.status <= ST_BUBBLE;
		end else if (!stall) begin
			stage[0] <= fwd_in;
			for (int i = 1; i < QUERY_LAT; i++) begin
				stage[i] <= stage[i-1];
			end
			entry_out.item  <= stage[QUERY_LAT-1];
			entry_out.query <= query_base;  // base for the item just leaving
		end
	end

endmodule

// ==== hw/read_queue.sv ====
//======================================================================
// circular queue of aligned read entries
// only init/run/break entries are stored, anything else is dropped
// pointers carry one wrap bit, so all QUEUE_DEPTH slots are usable
// the writer must not overflow the queue, there is no full flag
//======================================================================
`timescale 1ns/1ps

module read_queue
	import smem_queue_pkg::*;
(
	input  logic         Clk_32UI,
	input  logic         reset_n,
	input  logic         stall,
	input  queue_entry_t entry_in,
	input  logic         pop,
	output queue_entry_t head,
	output logic         empty
);

	queue_entry_t             mem [QUEUE_DEPTH];
	logic [QUEUE_PTR_W:0]     wr_ptr;
	logic [QUEUE_PTR_W:0]     rd_ptr;
	logic                     push;

	assign push = !stall && ((entry_in.item.status == ST_F_INIT) ||
		(entry_in.item.status == ST_F_RUN) || (entry_in.item.status == ST_F_BREAK));

	// storage, no reset on the slots
	always_ff @(posedge Clk_32UI) begin
		if (push) begin
			mem[wr_ptr[QUEUE_PTR_W-1:0]] <= entry_in;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (!stall) begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	assign empty = (wr_ptr == rd_ptr);
	assign head  = mem[rd_ptr[QUEUE_PTR_W-1:0]];  // valid one edge after write

endmodule

// ==== hw/smem_queue.sv ====
//======================================================================
// forward read-scheduling queue, top level
// query_base must follow query_req by QUERY_LAT unstalled cycles
// stall freezes everything except the DRAM response write
// DRAM responses must never exceed MAX_READ outstanding
//======================================================================
`timescale 1ns/1ps

module smem_queue
	import smem_queue_pkg::*;
(
	input  logic               Clk_32UI,
	input  logic               reset_n,
	input  logic               stall,
	// forward pipeline return path
	input  fwd_item_t          fwd_in,
	input  query_req_t         query_req,
	output query_req_t         query_2ram,
	input  logic [QUERY_W-1:0] query_base,
	// DRAM responses
	input  logic               dram_get,
	input  occ_entry_t         occ_in,
	// read loader
	input  logic               new_read_valid,
	input  new_read_t          new_read_in,
	output logic               new_read,
	// to the forward pipeline
	output queue_entry_t       fwd_out,
	output occ_entry_t         occ_out
);

	queue_entry_t aligned;
	queue_entry_t head;
	logic         queue_empty;
	logic         queue_pop;
	logic         occ_pop;
	logic         occ_valid;

	assign query_2ram = query_req;  // straight to the read RAM

	query_align i_query_align (
		.Clk_32UI   (Clk_32UI),
		.reset_n    (reset_n),
		.stall      (stall),
		.fwd_in     (fwd_in),
		.query_base (query_base),
		.entry_out  (aligned)
	);

	read_queue i_read_queue (
		.Clk_32UI (Clk_32UI),
		.reset_n  (reset_n),
		.stall    (stall),
		.entry_in (aligned),
		.pop      (queue_pop),
		.head     (head),
		.empty    (queue_empty)
	);

	occ_fifo i_occ_fifo (
		.Clk_32UI  (Clk_32UI),
		.reset_n   (reset_n),
		.stall     (stall),
		.dram_get  (dram_get),
		.occ_in    (occ_in),
		.pop       (occ_pop),
		.occ_valid (occ_valid),
		.occ_out   (occ_out)
	);

	issue_ctrl i_issue_ctrl (
		.Clk_32UI       (Clk_32UI),
		.reset_n        (reset_n),
		.stall          (stall),
		.head           (head),
		.queue_empty    (queue_empty),
		.occ_valid      (occ_valid),
		.new_read_valid (new_read_valid),
		.new_read_in    (new_read_in),
		.queue_pop      (queue_pop),
		.occ_pop        (occ_pop),
		.new_read       (new_read),
		.fwd_out        (fwd_out)
	);

endmodule

// ==== hw/smem_queue_pkg.sv ====
//======================================================================
// shared sizes, status codes and payload structs for the forward queue
// intervals are kept at stored width (33-bit bounds, 7+7-bit info)
// status codes follow the forward pipeline encoding, bubble = 6'b110000
//======================================================================
package smem_queue_pkg;

	//======================================================================
	// sizes
	//======================================================================
	localparam int MAX_READ    = 64;   // reads in flight
	localparam int READ_NUM_W  = 6;
	localparam int POS_W       = 7;    // query position / loop index
	localparam int QUERY_W     = 8;    // one query base
	localparam int IK_W        = 33;
	localparam int INFO_W      = 7;
	localparam int QUEUE_DEPTH = 2 * MAX_READ;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int QUERY_LAT   = 3;    // read RAM latency

	typedef logic [5:0] status_t;

	localparam status_t ST_F_INIT  = 6'd0;
	localparam status_t ST_F_RUN   = 6'd1;  // waits for occ counts
	localparam status_t ST_F_BREAK = 6'd2;  // goes out without memory
	localparam status_t ST_BUBBLE  = 6'b110000;

	//======================================================================
	// payload types
	//======================================================================
	typedef struct packed {
		logic [IK_W-1:0]   x0;
		logic [IK_W-1:0]   x1;
		logic [IK_W-1:0]   x2;
		logic [INFO_W-1:0] info_hi;
		logic [INFO_W-1:0] info_lo;
	} bi_interval_t;

	typedef struct packed {
		status_t               status;
		logic [POS_W-1:0]      ptr_curr;
		logic [READ_NUM_W-1:0] read_num;
		bi_interval_t          ik;
		logic [POS_W-1:0]      forward_i;
		logic [POS_W-1:0]      min_intv;
		logic [POS_W-1:0]      backward_x;
	} fwd_item_t;

	typedef struct packed {
		fwd_item_t          item;
		logic [QUERY_W-1:0] query;  // next base of the read
	} queue_entry_t;

	typedef struct packed {
		logic [POS_W-1:0]      position;
		logic [READ_NUM_W-1:0] read_num;
		status_t               status;
	} query_req_t;

	typedef struct packed {
		logic [READ_NUM_W-1:0] read_num;
		bi_interval_t          ik;
		logic [POS_W-1:0]      forward_i;
		logic [POS_W-1:0]      min_intv;
	} new_read_t;

	// one DRAM occurrence response, 768 bits
	typedef struct packed {
		logic [3:0][31:0] cnt_a;
		logic [3:0][63:0] cnt_b;
		logic [3:0][31:0] cntl_a;
		logic [3:0][63:0] cntl_b;
	} occ_entry_t;

endpackage

// ==== src.f ====
hw/smem_queue_pkg.sv
hw/query_align.sv
hw/read_queue.sv
hw/occ_fifo.sv
hw/issue_ctrl.sv
hw/smem_queue.sv
test/tb_smem_queue.sv

// ==== test/tb_smem_queue.sv ====
//======================================================================
// directed testbench for the forward read-scheduling queue
// a small RAM model answers query_2ram QUERY_LAT unstalled edges later
// inputs change on the rising edge, outputs are sampled on the falling
//======================================================================
`timescale 1ns/1ps

module tb_smem_queue
	import smem_queue_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 3000;  // ten times the summed test lengths
	localparam int WAIT_LIMIT     = 40;    // per item on fwd_out
	localparam int FWD_LAT        = 7;     // capture edge to fwd_out, lone item

	logic               Clk_32UI = 1'b0;
	logic               reset_n;
	logic               stall;
	fwd_item_t          fwd_in;
	query_req_t         query_req;
	query_req_t         query_2ram;
	logic [QUERY_W-1:0] query_base = '0;
	logic               dram_get;
	occ_entry_t         occ_in;
	logic               new_read_valid;
	new_read_t          new_read_in;
	logic               new_read;
	queue_entry_t       fwd_out;
	occ_entry_t         occ_out;

	int                 seed = 49;
	int                 cycle_cnt = 0;
	int                 err_fwd = 0;
	int                 err_occ = 0;
	int                 err_ctrl = 0;
	int                 err_other = 0;
	queue_entry_t       exp_q[$];  // scoreboard, issue order
	occ_entry_t         occ_q[$];
	logic [POS_W-1:0]   pos_d1 = '0;
	logic [POS_W-1:0]   pos_d2 = '0;

	always #2 Clk_32UI = ~Clk_32UI;

	smem_queue i_dut (
		.Clk_32UI       (Clk_32UI),
		.reset_n        (reset_n),
		.stall          (stall),
		.fwd_in         (fwd_in),
		.query_req      (query_req),
		.query_2ram     (query_2ram),
		.query_base     (query_base),
		.dram_get       (dram_get),
		.occ_in         (occ_in),
		.new_read_valid (new_read_valid),
		.new_read_in    (new_read_in),
		.new_read       (new_read),
		.fwd_out        (fwd_out),
		.occ_out        (occ_out)
	);

	//======================================================================
	// models and helpers
	//======================================================================
	// read RAM contents, one base per query position
	function automatic logic [QUERY_W-1:0] base_of(input logic [POS_W-1:0] pos);
		return {pos, 1'b1} ^ 8'h3c;
	endfunction

	// read RAM, holds its pipeline through stall
	always @(posedge Clk_32UI) begin
		if (!stall) begin
			pos_d1     <= query_2ram.position;
			pos_d2     <= pos_d1;
			query_base <= base_of(pos_d2);
		end
	end

	always @(posedge Clk_32UI) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles, tests did not finish", cycle_cnt);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic logic [63:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic bi_interval_t rand_interval();
		bi_interval_t ik;
		logic [63:0]  r;
		r = rand64();
		ik.x0 = r[IK_W-1:0];
		r = rand64();
		ik.x1 = r[IK_W-1:0];
		r = rand64();
		ik.x2 = r[IK_W-1:0];
		ik.info_hi = r[63:57];
		ik.info_lo = r[56:50];
		return ik;
	endfunction

	function automatic occ_entry_t rand_occ();
		occ_entry_t o;
		for (int i = 0; i < 24; i++) begin
			o[i*32 +: 32] = $random(seed);
		end
		return o;
	endfunction

	function automatic new_read_t rand_read();
		new_read_t   nr;
		logic [63:0] r;
		r = rand64();
		nr.read_num  = r[READ_NUM_W-1:0];
		nr.forward_i = r[20:14];
		nr.min_intv  = r[30:24];
		nr.ik        = rand_interval();
		return nr;
	endfunction

	// first round of a fresh read as issued to the forward pipeline
	function automatic queue_entry_t expected_fresh(input new_read_t nr);
		queue_entry_t e;
		e.item.status     = ST_F_INIT;
		e.item.ptr_curr   = '0;
		e.item.read_num   = nr.read_num;
		e.item.ik         = nr.ik;
		e.item.forward_i  = nr.forward_i + 7'd1;
		e.item.backward_x = nr.forward_i;
		e.item.min_intv   = nr.min_intv;
		e.query           = '0;
		return e;
	endfunction

	// one returned item for one cycle, query request alongside
	task automatic drive_item(input status_t st, input logic [POS_W-1:0] pos);
		fwd_item_t    it;
		query_req_t   q;
		queue_entry_t e;
		logic [63:0]  r;
		r = rand64();
		it.status     = st;
		it.ptr_curr   = pos;
		it.read_num   = r[READ_NUM_W-1:0];
		it.ik         = rand_interval();
		it.forward_i  = r[20:14];
		it.min_intv   = r[30:24];
		it.backward_x = r[40:34];
		q.position    = pos;
		q.read_num    = it.read_num;
		q.status      = st;
		e.item        = it;
		e.query       = base_of(pos);
		@(posedge Clk_32UI);
		fwd_in    <= it;
		query_req <= q;
		exp_q.push_back(e);
	endtask

	task automatic drive_idle();
		@(posedge Clk_32UI);
		fwd_in.status <= ST_BUBBLE;
	endtask

	task automatic drive_occ();
		occ_entry_t o;
		o = rand_occ();
		@(posedge Clk_32UI);
		dram_get <= 1'b1;
		occ_in   <= o;
		occ_q.push_back(o);
	endtask

	task automatic compare_fwd();
		queue_entry_t e;
		if (exp_q.size() == 0) begin
			$display("item with status %h on fwd_out that was never sent", fwd_out.item.status);
			err_other++;
		end else begin
			e = exp_q.pop_front();
			if (fwd_out !== e) begin
				$display("** Error: fwd_out = %h, expected %h", fwd_out, e);
				err_fwd++;
			end
		end
	endtask

	task automatic compare_occ();
		occ_entry_t o;
		if (occ_q.size() == 0) begin
			$display("memory item issued with no DRAM response left");
			err_other++;
		end else begin
			o = occ_q.pop_front();
			if (occ_out !== o) begin
				$display("** Error: occ_out = %h, expected %h", occ_out, o);
				err_occ++;
			end
		end
	endtask

	// waits for the next non-bubble fwd_out, edges counted from the call
	task automatic check_next(input bit with_occ, output int edges);
		edges = 0;
		do begin
			@(posedge Clk_32UI);
			edges++;
			@(negedge Clk_32UI);
		end while (fwd_out.item.status == ST_BUBBLE && edges < WAIT_LIMIT);
		if (fwd_out.item.status == ST_BUBBLE) begin
			$display("no item reached fwd_out within %0d cycles", WAIT_LIMIT);
			err_other++;
		end else begin
			compare_fwd();
			if (with_occ) begin
				compare_occ();
			end
		end
	endtask

	//======================================================================
	// tests
	//======================================================================
	task automatic test_reset();
		query_req_t q;
		logic [63:0] r;
		r = rand64();
		q = r[$bits(query_req_t)-1:0];
		@(negedge Clk_32UI);
		if (fwd_out.item.status !== ST_BUBBLE) begin
			$display("** Error: fwd_out.item.status = %h, expected %h", fwd_out.item.status, ST_BUBBLE);
			err_fwd++;
		end
		@(posedge Clk_32UI);
		query_req      <= q;
		stall          <= 1'b1;
		new_read_valid <= 1'b1;  // blocked by stall
		@(negedge Clk_32UI);
		if (query_2ram !== q) begin
			$display("** Error: query_2ram = %h, expected %h", query_2ram, q);
			err_ctrl++;
		end
		if (new_read !== 1'b0) begin
			$display("** Error: new_read = %h, expected %h", new_read, 1'b0);
			err_ctrl++;
		end
		@(posedge Clk_32UI);
		stall          <= 1'b0;
		new_read_valid <= 1'b0;
		@(negedge Clk_32UI);
		if (new_read !== 1'b0) begin
			$display("** Error: new_read = %h, expected %h", new_read, 1'b0);
			err_ctrl++;
		end
	endtask

	task automatic test_new_read();
		new_read_t n1;
		new_read_t n2;
		int        edges;
		n1 = rand_read();
		n2 = rand_read();
		@(posedge Clk_32UI);
		new_read_valid <= 1'b1;
		new_read_in    <= n1;
		exp_q.push_back(expected_fresh(n1));
		@(negedge Clk_32UI);
		if (new_read !== 1'b1) begin
			$display("** Error: new_read = %h, expected %h", new_read, 1'b1);
			err_ctrl++;
		end
		@(posedge Clk_32UI);  // n1 consumed here
		new_read_in <= n2;
		exp_q.push_back(expected_fresh(n2));
		@(negedge Clk_32UI);
		if (new_read !== 1'b0) begin
			$display("** Error: new_read = %h, expected %h", new_read, 1'b0);
			err_ctrl++;
		end
		@(posedge Clk_32UI);
		@(negedge Clk_32UI);
		compare_fwd();
		if (new_read !== 1'b1) begin
			$display("** Error: new_read = %h, expected %h", new_read, 1'b1);
			err_ctrl++;
		end
		@(posedge Clk_32UI);  // n2 consumed
		new_read_valid <= 1'b0;
		@(negedge Clk_32UI);
		if (fwd_out.item.status !== ST_BUBBLE) begin
			$display("** Error: fwd_out.item.status = %h, expected %h", fwd_out.item.status, ST_BUBBLE);
			err_fwd++;
		end
		check_next(1'b0, edges);
	endtask

	task automatic test_break();
		int edges;
		drive_item(ST_F_BREAK, 7'd5);
		drive_idle();  // lone item captured here
		check_next(1'b0, edges);
		if (edges + 1 != FWD_LAT) begin
			$display("lone break item took %0d edges instead of %0d", edges + 1, FWD_LAT);
			err_other++;
		end
		drive_item(ST_F_BREAK, 7'd17);
		drive_item(ST_F_BREAK, 7'd33);
		drive_item(ST_F_BREAK, 7'd100);
		drive_idle();
		repeat (3) check_next(1'b0, edges);
	endtask

	task automatic test_run();
		int edges;
		drive_item(ST_F_RUN, 7'd9);
		drive_item(ST_F_RUN, 7'd64);
		drive_idle();
		repeat (12) begin
			@(negedge Clk_32UI);
			if (fwd_out.item.status !== ST_BUBBLE) begin
				$display("run item issued before any DRAM response");
				err_other++;
			end
		end
		drive_occ();
		drive_occ();
		@(posedge Clk_32UI);
		dram_get <= 1'b0;
		repeat (2) check_next(1'b1, edges);
	endtask

	task automatic test_stall();
		queue_entry_t held_fwd;
		occ_entry_t   held_occ;
		int           edges;
		drive_item(ST_F_BREAK, 7'd21);
		drive_item(ST_F_BREAK, 7'd42);
		drive_item(ST_F_RUN, 7'd77);
		drive_idle();
		repeat (4) @(posedge Clk_32UI);  // first item on fwd_out after this edge
		stall <= 1'b1;
		@(negedge Clk_32UI);
		held_fwd = fwd_out;
		held_occ = occ_out;
		compare_fwd();
		drive_occ();  // written while stalled
		@(posedge Clk_32UI);
		dram_get <= 1'b0;
		repeat (4) begin
			@(negedge Clk_32UI);
			if (fwd_out !== held_fwd) begin
				$display("** Error: fwd_out = %h, expected %h", fwd_out, held_fwd);
				err_fwd++;
			end
			if (occ_out !== held_occ) begin
				$display("** Error: occ_out = %h, expected %h", occ_out, held_occ);
				err_occ++;
			end
			@(posedge Clk_32UI);
		end
		stall <= 1'b0;
		check_next(1'b0, edges);
		check_next(1'b1, edges);
	endtask

	//======================================================================
	// main sequence
	//======================================================================
	initial begin
		reset_n        = 1'b0;
		stall          = 1'b0;
		fwd_in         = '0;
		fwd_in.status  = ST_BUBBLE;
		query_req      = '0;
		dram_get       = 1'b0;
		occ_in         = '0;
		new_read_valid = 1'b0;
		new_read_in    = '0;
		repeat (10) @(posedge Clk_32UI);
		reset_n <= 1'b1;
		test_reset();
		test_new_read();
		repeat (4) @(posedge Clk_32UI);
		test_break();
		repeat (4) @(posedge Clk_32UI);
		test_run();
		repeat (4) @(posedge Clk_32UI);
		test_stall();
		repeat (4) @(posedge Clk_32UI);
		if (exp_q.size() != 0 || occ_q.size() != 0) begin
			$display("%0d items and %0d responses never came out", exp_q.size(), occ_q.size());
			err_other++;
		end
		$display("errors: fwd_out %0d, occ_out %0d, control %0d, other %0d",
			err_fwd, err_occ, err_ctrl, err_other);
		if (err_fwd + err_occ + err_ctrl + err_other == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
